// File: source/serial_pkg.sv
package serial_pkg;

    // dimensoes da grade
    localparam int LINHAS  = 4;
    localparam int COLUNAS = 8;
    localparam int CELULAS = LINHAS * COLUNAS;

    // larguras dos contadores e do indice de celula
    localparam int LIN_W = $clog2(LINHAS);
    localparam int COL_W = $clog2(COLUNAS + 1);
    localparam int CEL_W = $clog2(CELULAS);

    // temporizacao 8N1
    localparam int TICKS_POR_BIT   = 8;
    localparam int TICK_W          = $clog2(TICKS_POR_BIT);
    localparam int BITS_POR_QUADRO = 10;
    localparam int BIT_W           = $clog2(BITS_POR_QUADRO);

    // caracteres ascii
    localparam logic [7:0] CAR_CHEIO      = 8'h23;
    localparam logic [7:0] CAR_VAZIO      = 8'h2E;
    localparam logic [7:0] CAR_NOVA_LINHA = 8'h0A;

    // celula (r, c) fica no bit r*COLUNAS + c
    localparam logic [CELULAS-1:0] PADRAO_INICIAL = CELULAS'(32'h3C81A55A);

    // estados da unidade de controle
    typedef enum logic [3:0] {
        inicial           = 4'd0,
        preparado         = 4'd1,
        transmite         = 4'd2,
        espera            = 4'd3,
        proximo_caractere = 4'd4,
        proxima_linha     = 4'd5,
        finaliza          = 4'd6
    } estado_t;

endpackage

// File: source/fd_uc_if.sv
interface fd_uc_if;

    // comandos, pulsos de um ciclo
    logic partida_serial;
    logic conta_coluna;
    logic zera_coluna;
    logic conta_linha;
    logic zera_linha;
    logic flipa;

    // condicoes vindas do fluxo de dados
    logic pronto;
    logic fim_coluna;
    logic fim_linha;

    modport uc (
        output partida_serial, conta_coluna, zera_coluna, conta_linha, zera_linha, flipa,
        input  pronto, fim_coluna, fim_linha
    );

    modport fd (
        input  partida_serial, conta_coluna, zera_coluna, conta_linha, zera_linha, flipa,
        output pronto, fim_coluna, fim_linha
    );

endinterface

// File: source/uart_tx_serial.sv
module uart_tx_serial import serial_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  logic       partida,
    input  logic [7:0] dado,
    output logic       saida,
    output logic       pronto
);

    logic [BITS_POR_QUADRO-1:0] deslocador;
    logic [TICK_W-1:0]          cont_tick;
    logic [BIT_W-1:0]           cont_bit;
    logic                       ocupado;
    logic                       fim_tick;
    logic                       ultimo_bit;

    assign fim_tick   = (cont_tick == TICK_W'(TICKS_POR_BIT - 1));
    assign ultimo_bit = (cont_bit == BIT_W'(BITS_POR_QUADRO - 1));

    // contadores de tick e de bit
    always_ff @(posedge clock) begin
        if (rst) begin
            ocupado   <= 1'b0;
            cont_tick <= '0;
            cont_bit  <= '0;
        end else if (partida) begin
            ocupado   <= 1'b1;
            cont_tick <= '0;
            cont_bit  <= '0;
        end else if (ocupado) begin
            if (fim_tick) begin
                cont_tick <= '0;
                if (ultimo_bit) begin
                    ocupado  <= 1'b0;
                    cont_bit <= '0;
                end else begin
                    cont_bit <= cont_bit + 1'b1;
                end
            end else begin
                cont_tick <= cont_tick + 1'b1;
            end
        end
    end

    // quadro: stop, dado (lsb primeiro), start no bit 0
    always_ff @(posedge clock) begin
        if (partida) begin
            deslocador <= {1'b1, dado, 1'b0};
        end else if (ocupado && fim_tick) begin
            deslocador <= {1'b1, deslocador[BITS_POR_QUADRO-1:1]};
        end
    end

    // linha em repouso fica alta
    assign saida  = ocupado ? deslocador[0] : 1'b1;

    // ultimo ciclo do stop bit
    assign pronto = ocupado && ultimo_bit && fim_tick;

endmodule

// File: source/uart_fd.sv
module uart_fd import serial_pkg::*; (
    input  logic clock,
    input  logic rst,
    fd_uc_if.fd  ctrl,
    output logic saida_serial
);

    logic [LIN_W-1:0]   linha;
    logic [COL_W-1:0]   coluna;
    logic [CELULAS-1:0] grade;
    logic [CEL_W-1:0]   indice;
    logic [7:0]         caractere;
    logic               celula;

    // contador de colunas, vai ate COLUNAS (nova linha)
    always_ff @(posedge clock) begin
        if (rst) begin
            coluna <= '0;
        end else if (ctrl.zera_coluna) begin
            coluna <= '0;
        end else if (ctrl.conta_coluna) begin
            coluna <= coluna + 1'b1;
        end
    end

    // contador de linhas
    always_ff @(posedge clock) begin
        if (rst) begin
            linha <= '0;
        end else if (ctrl.zera_linha) begin
            linha <= '0;
        end else if (ctrl.conta_linha) begin
            linha <= linha + 1'b1;
        end
    end

    // grade, invertida ao fim de cada quadro
    always_ff @(posedge clock) begin
        if (rst) begin
            grade <= PADRAO_INICIAL;
        end else if (ctrl.flipa) begin
            grade <= ~grade;
        end
    end

    // celula selecionada: linha*COLUNAS + coluna
    assign indice = CEL_W'(linha * COLUNAS) + CEL_W'(coluna);
    assign celula = grade[indice];

    // escolha do caractere
    always_comb begin
        if (ctrl.fim_coluna) begin
            caractere = CAR_NOVA_LINHA;
        end else if (celula) begin
            caractere = CAR_CHEIO;
        end else begin
            caractere = CAR_VAZIO;
        end
    end

    assign ctrl.fim_coluna = (coluna == COL_W'(COLUNAS));
    assign ctrl.fim_linha  = (linha == LIN_W'(LINHAS - 1));

    // transmissor serial
    uart_tx_serial u_tx (
        .clock   ( clock               ),
        .rst     ( rst                 ),
        .partida ( ctrl.partida_serial ),
        .dado    ( caractere           ),
        .saida   ( saida_serial        ),
        .pronto  ( ctrl.pronto         )
    );

endmodule

// File: source/uart_uc.sv
module uart_uc import serial_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  logic       iniciar,
    fd_uc_if.uc        ctrl,
    output logic       fim,
    output logic [3:0] db_estado
);

    estado_t estado;
    estado_t proximo;

    // registro de estado
    always_ff @(posedge clock) begin
        if (rst) begin
            estado <= inicial;
        end else begin
            estado <= proximo;
        end
    end

    // transicoes
    always_comb begin
        proximo = estado;
        case (estado)
            inicial: begin
                if (iniciar) begin
                    proximo = preparado;
                end
            end
            preparado: begin
                proximo = transmite;
            end
            transmite: begin
                proximo = espera;
            end
            espera: begin
                // decide so no fim do stop bit
                if (ctrl.pronto) begin
                    if (!ctrl.fim_coluna) begin
                        proximo = proximo_caractere;
                    end else if (!ctrl.fim_linha) begin
                        proximo = proxima_linha;
                    end else begin
                        proximo = finaliza;
                    end
                end
            end
            proximo_caractere: begin
                proximo = transmite;
            end
            proxima_linha: begin
                proximo = transmite;
            end
            finaliza: begin
                proximo = inicial;
            end
            default: begin
                proximo = inicial;
            end
        endcase
    end

    // saidas de moore, pulsos de um ciclo
    always_comb begin
        ctrl.partida_serial = 1'b0;
        ctrl.conta_coluna   = 1'b0;
        ctrl.zera_coluna    = 1'b0;
        ctrl.conta_linha    = 1'b0;
        ctrl.zera_linha     = 1'b0;
        ctrl.flipa          = 1'b0;
        fim                 = 1'b0;
        case (estado)
            preparado: begin
                ctrl.zera_coluna = 1'b1;
                ctrl.zera_linha  = 1'b1;
            end
            transmite: begin
                ctrl.partida_serial = 1'b1;
            end
            proximo_caractere: begin
                ctrl.conta_coluna = 1'b1;
            end
            proxima_linha: begin
                ctrl.zera_coluna = 1'b1;
                ctrl.conta_linha = 1'b1;
            end
            finaliza: begin
                fim        = 1'b1;
                ctrl.flipa = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign db_estado = estado;

endmodule

// File: source/hexa7seg.sv
module hexa7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    // segmentos g f e d c b a, ativos em baixo
    always_comb begin
        case (hexa)
            4'h0:    display = 7'b1000000;
            4'h1:    display = 7'b1111001;
            4'h2:    display = 7'b0100100;
            4'h3:    display = 7'b0110000;
            4'h4:    display = 7'b0011001;
            4'h5:    display = 7'b0010010;
            4'h6:    display = 7'b0000010;
            4'h7:    display = 7'b1111000;
            4'h8:    display = 7'b0000000;
            4'h9:    display = 7'b0010000;
            4'hA:    display = 7'b0001000;
            // b e d em minusculo
            4'hB:    display = 7'b0000011;
            4'hC:    display = 7'b1000110;
            4'hD:    display = 7'b0100001;
            4'hE:    display = 7'b0000110;
            4'hF:    display = 7'b0001110;
            default: display = 7'b1111111;
        endcase
    end

endmodule

// File: source/transmissao_serial.sv
module transmissao_serial (
    input  logic       clock,
    input  logic       rst,
    input  logic       iniciar,
    output logic       saida_serial,
    output logic       fim,
    output logic       db_partida_serial,
    output logic       db_saida_serial,
    output logic [6:0] db_estado
);

    logic       s_saida_serial;
    logic [3:0] s_db_estado;

    // comandos e condicoes entre uc e fd
    fd_uc_if s_ctrl ();

    // fluxo de dados
    uart_fd u1_fd (
        .clock        ( clock          ),
        .rst          ( rst            ),
        .ctrl         ( s_ctrl.fd      ),
        .saida_serial ( s_saida_serial )
    );

    // unidade de controle
    uart_uc u2_uc (
        .clock     ( clock       ),
        .rst       ( rst         ),
        .iniciar   ( iniciar     ),
        .ctrl      ( s_ctrl.uc   ),
        .fim       ( fim         ),
        .db_estado ( s_db_estado )
    );

    // codigo do estado no display
    hexa7seg hexa_estado (
        .hexa    ( s_db_estado ),
        .display ( db_estado   )
    );

    assign saida_serial = s_saida_serial;

    // depuracao
    assign db_partida_serial = s_ctrl.partida_serial;
    assign db_saida_serial   = s_saida_serial;

endmodule

// File: bench/tb_receptor_serial.sv
module tb_receptor_serial (
    input  logic       clock,
    input  logic       linha,
    output logic [7:0] dado,
    output logic       recebido,
    output logic       erro_quadro
);

    timeunit 1ns;
    timeprecision 1ps;

    // copia local da duracao de um bit
    localparam int TICKS = 8;

    logic [7:0] bits;

    // amostra na borda de subida, no meio de cada bit
    always begin
        @(posedge clock);
        recebido    <= 1'b0;
        erro_quadro <= 1'b0;
        if (!linha) begin
            // meio do start bit
            repeat (TICKS / 2 - 1) @(posedge clock);
            if (linha) begin
                // start falso, linha voltou a subir
                erro_quadro <= 1'b1;
            end else begin
                bits = '0;
                // dados, lsb primeiro
                repeat (8) begin
                    repeat (TICKS) @(posedge clock);
                    bits = {linha, bits[7:1]};
                end
                // meio do stop bit
                repeat (TICKS) @(posedge clock);
                dado        <= bits;
                recebido    <= 1'b1;
                erro_quadro <= !linha;
            end
        end
    end

endmodule

// File: bench/tb_transmissao_serial.sv
module tb_transmissao_serial import serial_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_QUADROS   = 4;
    localparam int CARACTERES    = LINHAS * (COLUNAS + 1);
    localparam int IDX_W         = $clog2(CARACTERES);
    // 10 bits por caractere mais 2 ciclos de intervalo
    localparam int CICLOS_QUADRO = CARACTERES * (10 * TICKS_POR_BIT + 2) + 4;
    localparam int LIMITE_CICLOS = (NUM_QUADROS + 2) * (CICLOS_QUADRO + 64) + 16;
    // digito 0 em g f e d c b a, ativo em baixo
    localparam logic [6:0] SEG_INICIAL = 7'b1000000;

    logic       clock = 1'b0;
    logic       rst;
    logic       iniciar;
    logic       saida_serial;
    logic       fim;
    logic       db_partida_serial;
    logic       db_saida_serial;
    logic [6:0] db_estado;
    logic [7:0] rx_dado;
    logic       rx_valido;
    logic       rx_erro;

    logic [31:0]        semente;
    logic [CELULAS-1:0] modelo;
    logic [7:0]         esperados[$];
    logic [7:0]         quadro_atual[CARACTERES];
    logic [7:0]         quadro_anterior[CARACTERES];

    int erros_valor     = 0;
    int erros_outros    = 0;
    int idx_car         = 0;
    int partidas_quadro = 0;
    int total_car       = 0;
    int total_fim       = 0;
    int quadros_rx      = 0;
    int ciclos_alto     = 0;

    always #10 clock = ~clock;

    transmissao_serial dut_i (
        .clock             ( clock             ),
        .rst               ( rst               ),
        .iniciar           ( iniciar           ),
        .saida_serial      ( saida_serial      ),
        .fim               ( fim               ),
        .db_partida_serial ( db_partida_serial ),
        .db_saida_serial   ( db_saida_serial   ),
        .db_estado         ( db_estado         )
    );

    tb_receptor_serial rx_i (
        .clock       ( clock        ),
        .linha       ( saida_serial ),
        .dado        ( rx_dado      ),
        .recebido    ( rx_valido    ),
        .erro_quadro ( rx_erro      )
    );

    // lfsr de fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] estado);
        logic realim;
        realim = estado[31] ^ estado[21] ^ estado[1] ^ estado[0];
        return {estado[30:0], realim};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] valor);
        valor = '0;
        for (int i = 0; i < n; i++) begin
            semente = lfsr_next(semente);
            valor   = {valor[30:0], semente[0]};
        end
    endtask

    function automatic logic [7:0] complement_char(input logic [7:0] c);
        if (c == CAR_CHEIO) return CAR_VAZIO;
        if (c == CAR_VAZIO) return CAR_CHEIO;
        return c;
    endfunction

    task automatic report_value_error(input string nome, input logic [31:0] esperado,
                                      input logic [31:0] obtido);
        erros_valor++;
        $display("ERR t=%0t %s expected %0h got %0h", $time, nome, esperado, obtido);
    endtask

    task automatic report_fault(input string texto);
        erros_outros++;
        $display("t=%0t %s", $time, texto);
    endtask

    // linha por linha, nova linha no fim de cada uma
    task automatic build_expected_frame();
        for (int r = 0; r < LINHAS; r++) begin
            for (int c = 0; c < COLUNAS; c++) begin
                esperados.push_back(modelo[CEL_W'(r * COLUNAS + c)] ? CAR_CHEIO : CAR_VAZIO);
            end
            esperados.push_back(CAR_NOVA_LINHA);
        end
    endtask

    task automatic check_idle();
        if (saida_serial !== 1'b1) report_value_error("saida_serial", 32'd1, 32'(saida_serial));
        if (fim !== 1'b0) report_value_error("fim", 32'd0, 32'(fim));
        if (db_partida_serial !== 1'b0)
            report_value_error("db_partida_serial", 32'd0, 32'(db_partida_serial));
        if (db_estado !== SEG_INICIAL)
            report_value_error("db_estado", 32'(SEG_INICIAL), 32'(db_estado));
    endtask

    task automatic check_char();
        logic [7:0] esperado;
        if (esperados.size() == 0) begin
            report_fault("character received while no frame was expected");
        end else begin
            esperado = esperados.pop_front();
            if (rx_dado !== esperado)
                report_value_error("saida_serial char", 32'(esperado), 32'(rx_dado));
        end
        if (idx_car < CARACTERES) begin
            // quadro anterior invertido
            if (quadros_rx > 0 &&
                rx_dado !== complement_char(quadro_anterior[IDX_W'(idx_car)]))
                report_value_error("saida_serial complement",
                    32'(complement_char(quadro_anterior[IDX_W'(idx_car)])), 32'(rx_dado));
            quadro_atual[IDX_W'(idx_car)] = rx_dado;
        end
        idx_car++;
        total_car++;
    endtask

    task automatic check_frame_end();
        if (idx_car != CARACTERES)
            report_value_error("characters per frame", 32'(CARACTERES), 32'(idx_car));
        if (partidas_quadro != CARACTERES)
            report_value_error("db_partida_serial pulses", 32'(CARACTERES), 32'(partidas_quadro));
        if (ciclos_alto <= TICKS_POR_BIT)
            report_fault("fim pulsed before the last stop bit had finished");
        quadro_anterior = quadro_atual;
        idx_car         = 0;
        partidas_quadro = 0;
        quadros_rx++;
        total_fim++;
    endtask

    // monitor das saidas
    always @(posedge clock) begin
        if (!rst) begin
            if (db_saida_serial !== saida_serial)
                report_value_error("db_saida_serial", 32'(saida_serial), 32'(db_saida_serial));
            if (saida_serial) ciclos_alto++;
            else ciclos_alto = 0;
            if (db_partida_serial) partidas_quadro++;
            if (rx_erro) report_fault("framing fault on saida_serial (bad start or stop bit)");
            if (rx_valido) check_char();
            if (fim) check_frame_end();
        end
    end

    // pulsos aleatorios de iniciar enquanto o quadro corre
    task automatic drive_during_frame();
        logic [31:0] sorteio;
        logic        fim_visto;
        fim_visto = 1'b0;
        while (!fim_visto) begin
            @(posedge clock);
            if (fim) begin
                fim_visto = 1'b1;
                iniciar <= 1'b0;
            end else begin
                draw_bits(3, sorteio);
                iniciar <= (sorteio[2:0] == 3'b111);
            end
        end
    endtask

    initial begin
        logic [31:0] sorteio;
        rst     = 1'b1;
        iniciar = 1'b0;
        semente = 32'ha802cbe7;
        modelo  = PADRAO_INICIAL;
        repeat (16) @(posedge clock);
        rst <= 1'b0;
        @(posedge clock);
        check_idle();
        for (int q = 0; q < NUM_QUADROS; q++) begin
            build_expected_frame();
            draw_bits(6, sorteio);
            repeat (sorteio) begin
                @(posedge clock);
                check_idle();
            end
            iniciar <= 1'b1;
            @(posedge clock);
            check_idle();
            iniciar <= 1'b0;
            drive_during_frame();
            modelo = ~modelo;
        end
        repeat (8) begin
            @(posedge clock);
            check_idle();
        end
        if (total_fim != NUM_QUADROS)
            report_value_error("fim pulses", 32'(NUM_QUADROS), 32'(total_fim));
        if (total_car != NUM_QUADROS * CARACTERES)
            report_value_error("characters", 32'(NUM_QUADROS * CARACTERES), 32'(total_car));
        if (esperados.size() != 0) report_fault("some expected characters never arrived");
        $display("value errors: %0d, other errors: %0d", erros_valor, erros_outros);
        if (erros_valor + erros_outros == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMITE_CICLOS) @(posedge clock);
        report_fault("timeout: the run did not finish within the cycle limit");
        $display("value errors: %0d, other errors: %0d", erros_valor, erros_outros);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: build.f
source/serial_pkg.sv
source/fd_uc_if.sv
source/uart_tx_serial.sv
source/uart_fd.sv
source/uart_uc.sv
source/hexa7seg.sv
source/transmissao_serial.sv
bench/tb_receptor_serial.sv
bench/tb_transmissao_serial.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_transmissao_serial -f build.f

./obj_dir/Vtb_transmissao_serial | tee sim.log

if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
